// File: rtl/lane_fabric_defs.svh
// Size settings of the lane fabric
// Lane count, per-lane FIFO depth, data width and synchronizer length

`ifndef LANE_FABRIC_DEFS_SVH
`define LANE_FABRIC_DEFS_SVH

// Number of FIFO lanes (2, 4 or 8)
`define LANE_COUNT  4
// Entries in each lane RAM, a power of two
`define FIFO_DEPTH  8
`define DATA_WIDTH  16
// Flip-flops in each gray pointer synchronizer
`define SYNC_STAGES 2

`endif

// File: rtl/lane_fabric_pkg.sv
// Shared types of the lane fabric
// Lane number, item payload and FIFO pointer

`include "lane_fabric_defs.svh"

package lane_fabric_pkg;

    // Bits needed to number the lanes, never less than one
    localparam int LANE_W = (`LANE_COUNT > 1) ? $clog2(`LANE_COUNT) : 1;

    // Address bits of one lane RAM
    localparam int ADDR_W = $clog2(`FIFO_DEPTH);

    typedef logic [LANE_W-1:0] lane_id_t;

    // Item as it travels on both ports and as it sits in the lane RAM
    typedef struct packed {
        lane_id_t                lane;
        logic [`DATA_WIDTH-1:0]  data;
    } fabric_item_t;

    // Pointer with one wrap bit above the RAM address
    typedef logic [ADDR_W:0] ptr_t;

endpackage

// File: rtl/fifo_ctl_dc.sv
// Dual-clock FIFO controller for one lane
// Binary and gray pointers, pointer synchronizers, RAM array and read pipeline

`timescale 1ns/1ns
`include "lane_fabric_defs.svh"

module fifo_ctl_dc
    import lane_fabric_pkg::*;
(
     input  logic           clk_push
    ,input  logic           clk_pop
    ,input  logic           rst_push_n
    ,input  logic           rst_pop_n

    ,input  logic           push
    ,input  fabric_item_t   push_item
    ,output logic           full

    ,input  logic [1:0]     db_occupancy
    ,output logic           rd_valid
    ,output fabric_item_t   rd_item
);

// Only one bit changes per increment, so a sampled value is always a real pointer
function automatic ptr_t bin2gray(input ptr_t b);
    return b ^ (b >> 1);
endfunction

function automatic ptr_t gray2bin(input ptr_t g);
    ptr_t b;
    b[ADDR_W] = g[ADDR_W];
    for (int i = ADDR_W - 1; i >= 0; i--) begin
        b[i] = b[i+1] ^ g[i];
    end
    return b;
endfunction

fabric_item_t   mem [`FIFO_DEPTH];

ptr_t           wr_bin_q;
ptr_t           wr_bin_nxt;
ptr_t           wr_gray_q;
ptr_t           rd_bin_q;
ptr_t           rd_bin_nxt;
ptr_t           rd_gray_q;
ptr_t           rd_gray_sync [`SYNC_STAGES];
ptr_t           wr_gray_sync [`SYNC_STAGES];
ptr_t           rd_bin_push;
logic           wr_en;
logic           rd_en;
logic           empty;

//--------------------------------------------------
// Push side
//--------------------------------------------------

// Read pointer as seen in clk_push, a few cycles late, so full is pessimistic
assign rd_bin_push = gray2bin(rd_gray_sync[`SYNC_STAGES-1]);

// Full when the addresses meet and the wrap bits differ
assign full  = (wr_bin_q[ADDR_W] != rd_bin_push[ADDR_W]) &&
               (wr_bin_q[ADDR_W-1:0] == rd_bin_push[ADDR_W-1:0]);
assign wr_en = push & ~full;
assign wr_bin_nxt = wr_bin_q + ptr_t'(1);

always_ff @(posedge clk_push or negedge rst_push_n) begin
    if (!rst_push_n) begin
        wr_bin_q  <= '0;
        wr_gray_q <= '0;
    end else if (wr_en) begin
        wr_bin_q  <= wr_bin_nxt;
        wr_gray_q <= bin2gray(wr_bin_nxt);
    end
end

// Gray read pointer into the push domain
always_ff @(posedge clk_push or negedge rst_push_n) begin
    if (!rst_push_n) begin
        rd_gray_sync <= '{default: '0};
    end else begin
        rd_gray_sync[0] <= rd_gray_q;
        for (int i = 1; i < `SYNC_STAGES; i++) begin
            rd_gray_sync[i] <= rd_gray_sync[i-1];
        end
    end
end

always_ff @(posedge clk_push) begin
    if (wr_en) begin
        mem[wr_bin_q[ADDR_W-1:0]] <= push_item;
    end
end

//--------------------------------------------------
// Pop side
//--------------------------------------------------

// Gray write pointer into the pop domain
always_ff @(posedge clk_pop or negedge rst_pop_n) begin
    if (!rst_pop_n) begin
        wr_gray_sync <= '{default: '0};
    end else begin
        wr_gray_sync[0] <= wr_gray_q;
        for (int i = 1; i < `SYNC_STAGES; i++) begin
            wr_gray_sync[i] <= wr_gray_sync[i-1];
        end
    end
end

assign empty = (rd_gray_q == wr_gray_sync[`SYNC_STAGES-1]);

// Read only while the buffer has room for this entry and the one in flight
assign rd_en = ~empty && (({1'b0, db_occupancy} + {2'b00, rd_valid}) < 3'd2);
assign rd_bin_nxt = rd_bin_q + ptr_t'(1);

always_ff @(posedge clk_pop or negedge rst_pop_n) begin
    if (!rst_pop_n) begin
        rd_bin_q  <= '0;
        rd_gray_q <= '0;
        rd_valid  <= 1'b0;
    end else begin
        rd_valid <= rd_en;
        if (rd_en) begin
            rd_bin_q  <= rd_bin_nxt;
            rd_gray_q <= bin2gray(rd_bin_nxt);
        end
    end
end

// Synchronous RAM read, the data lands with rd_valid
always_ff @(posedge clk_pop) begin
    if (rd_en) begin
        rd_item <= mem[rd_bin_q[ADDR_W-1:0]];
    end
end

endmodule

// File: rtl/double_buffer.sv
// Two-entry output buffer for a FIFO lane
// Payload type is a parameter, output always comes from a register

`timescale 1ns/1ns

module double_buffer
    import lane_fabric_pkg::*;
#(
     parameter type T = fabric_item_t
) (
     input  logic           clk
    ,input  logic           rst_n

    ,input  logic           in_valid
    ,input  T               in_data
    ,output logic [1:0]     occupancy

    ,input  logic           out_ready
    ,output logic           out_valid
    ,output T               out_data
);

T               entry_q [2];
logic           head_q;
logic           tail_q;
logic [1:0]     count_q;
logic           take_out;

// The writer checks occupancy first, so in_valid never meets a full buffer
assign take_out = out_ready & out_valid;

always_ff @(posedge clk) begin
    if (in_valid) begin
        entry_q[tail_q] <= in_data;
    end
end

// Head and tail toggle between the two slots, both may move in one cycle
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        head_q  <= 1'b0;
        tail_q  <= 1'b0;
        count_q <= 2'd0;
    end else begin
        head_q <= head_q ^ take_out;
        tail_q <= tail_q ^ in_valid;
        case ({in_valid, take_out})
            2'b10:   count_q <= count_q + 2'd1;
            2'b01:   count_q <= count_q - 2'd1;
            default: count_q <= count_q;
        endcase
    end
end

assign occupancy = count_q;
assign out_valid = (count_q != 2'd0);
assign out_data  = entry_q[head_q];

endmodule

// File: rtl/fifo_dc_wdb.sv
// One fabric lane
// Dual-clock FIFO controller, output double buffer and reset release per domain

`timescale 1ns/1ns

module fifo_dc_wdb
    import lane_fabric_pkg::*;
(
     input  logic           clk_push
    ,input  logic           clk_pop
    ,input  logic           arst_n

    ,input  logic           push
    ,input  fabric_item_t   push_item
    ,output logic           full

    ,input  logic           pop
    ,output logic           head_valid
    ,output fabric_item_t   head_item
);

logic [1:0]     rst_push_q;
logic [1:0]     rst_pop_q;
logic           rst_push_n;
logic           rst_pop_n;
logic           rd_valid;
fabric_item_t   rd_item;
logic [1:0]     db_occupancy;

//--------------------------------------------------
// Reset release, asserted at once and freed on a clock edge
//--------------------------------------------------

always_ff @(posedge clk_push or negedge arst_n) begin
    if (!arst_n) begin
        rst_push_q <= 2'b00;
    end else begin
        rst_push_q <= {rst_push_q[0], 1'b1};
    end
end

// The clk_pop copy also covers the double buffer
always_ff @(posedge clk_pop or negedge arst_n) begin
    if (!arst_n) begin
        rst_pop_q <= 2'b00;
    end else begin
        rst_pop_q <= {rst_pop_q[0], 1'b1};
    end
end

assign rst_push_n = rst_push_q[1];
assign rst_pop_n  = rst_pop_q[1];

fifo_ctl_dc u_fifo_ctl (
     .clk_push      (clk_push)
    ,.clk_pop       (clk_pop)
    ,.rst_push_n    (rst_push_n)
    ,.rst_pop_n     (rst_pop_n)
    ,.push          (push)
    ,.push_item     (push_item)
    ,.full          (full)
    ,.db_occupancy  (db_occupancy)
    ,.rd_valid      (rd_valid)
    ,.rd_item       (rd_item)
);

// RAM read time ends at the buffer, the pop path sees registers only
double_buffer #(.T(fabric_item_t)) u_db (
     .clk           (clk_pop)
    ,.rst_n         (rst_pop_n)
    ,.in_valid      (rd_valid)
    ,.in_data       (rd_item)
    ,.occupancy     (db_occupancy)
    ,.out_ready     (pop)
    ,.out_valid     (head_valid)
    ,.out_data      (head_item)
);

endmodule

// File: rtl/push_router.sv
// Push side router
// Four-phase input handshake and one-hot push into the target lane

`timescale 1ns/1ns
`include "lane_fabric_defs.svh"

module push_router
    import lane_fabric_pkg::*;
(
     input  logic                       clk_push
    ,input  logic                       arst_n

    ,input  logic                       in_req
    ,input  fabric_item_t               in_item
    ,output logic                       in_ack

    ,input  logic [`LANE_COUNT-1:0]     lane_full
    ,output logic [`LANE_COUNT-1:0]     push
    ,output fabric_item_t               push_item
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_ACK
} state_t;

state_t                     state_q;
logic [1:0]                 rst_sync_q;
logic                       rst_n;
logic [`LANE_COUNT-1:0]     lane_sel;

always_ff @(posedge clk_push or negedge arst_n) begin
    if (!arst_n) begin
        rst_sync_q <= 2'b00;
    end else begin
        rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
end

assign rst_n = rst_sync_q[1];

// One-hot decode of the requested lane
assign lane_sel = {{(`LANE_COUNT-1){1'b0}}, 1'b1} << in_item.lane;

//--------------------------------------------------
// Handshake FSM
//--------------------------------------------------

// A full target lane keeps the FSM in idle, which withholds in_ack
always_ff @(posedge clk_push or negedge rst_n) begin
    if (!rst_n) begin
        state_q <= ST_IDLE;
        push    <= '0;
        in_ack  <= 1'b0;
    end else begin
        push <= '0;
        case (state_q)
            ST_IDLE: if (in_req && !lane_full[in_item.lane]) begin
                push    <= lane_sel;
                state_q <= ST_WRITE;
            end
            // Item is written by now, acknowledge it
            ST_WRITE: begin
                in_ack  <= 1'b1;
                state_q <= ST_ACK;
            end
            ST_ACK: if (!in_req) begin
                in_ack  <= 1'b0;
                state_q <= ST_IDLE;
            end
            default: state_q <= ST_IDLE;
        endcase
    end
end

// Registered copy so every lane sees a stable word with the push pulse
always_ff @(posedge clk_push) begin
    if (state_q == ST_IDLE && in_req) begin
        push_item <= in_item;
    end
end

endmodule

// File: rtl/pop_arbiter.sv
// Pop side arbiter
// Round-robin lane grant and four-phase output handshake

`timescale 1ns/1ns
`include "lane_fabric_defs.svh"

module pop_arbiter
    import lane_fabric_pkg::*;
(
     input  logic                       clk_pop
    ,input  logic                       arst_n

    ,input  logic [`LANE_COUNT-1:0]     head_valid
    ,input  fabric_item_t               head_item [`LANE_COUNT]
    ,output logic [`LANE_COUNT-1:0]     pop

    ,output logic                       out_req
    ,output fabric_item_t               out_item
    ,input  logic                       out_ack
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_DONE
} state_t;

state_t         state_q;
logic [1:0]     rst_sync_q;
logic           rst_n;
lane_id_t       last_q;
lane_id_t       grant_idx;
logic           grant_valid;

always_ff @(posedge clk_pop or negedge arst_n) begin
    if (!arst_n) begin
        rst_sync_q <= 2'b00;
    end else begin
        rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
end

assign rst_n = rst_sync_q[1];

//--------------------------------------------------
// Round-robin search
//--------------------------------------------------

// Walk from the farthest lane back to the one after last_q, so the nearest wins
always_comb begin
    int cand;
    grant_valid = 1'b0;
    grant_idx   = last_q;
    for (int i = `LANE_COUNT; i >= 1; i--) begin
        cand = (int'(last_q) + i) % `LANE_COUNT;
        if (head_valid[cand]) begin
            grant_valid = 1'b1;
            grant_idx   = lane_id_t'(cand);
        end
    end
end

// Pop only in idle and only a lane whose head is valid
always_comb begin
    pop = '0;
    if (state_q == ST_IDLE && grant_valid) begin
        pop[grant_idx] = 1'b1;
    end
end

//--------------------------------------------------
// Output handshake
//--------------------------------------------------

always_ff @(posedge clk_pop or negedge rst_n) begin
    if (!rst_n) begin
        state_q <= ST_IDLE;
        out_req <= 1'b0;
        // Lane 0 is searched first after reset
        last_q  <= lane_id_t'(`LANE_COUNT - 1);
    end else begin
        case (state_q)
            ST_IDLE: if (grant_valid) begin
                out_req <= 1'b1;
                last_q  <= grant_idx;
                state_q <= ST_REQ;
            end
            ST_REQ: if (out_ack) begin
                out_req <= 1'b0;
                state_q <= ST_DONE;
            end
            // Sink must drop out_ack before the next grant
            ST_DONE: if (!out_ack) begin
                state_q <= ST_IDLE;
            end
            default: state_q <= ST_IDLE;
        endcase
    end
end

// Item is held from the pop until the handshake completes
always_ff @(posedge clk_pop) begin
    if (state_q == ST_IDLE && grant_valid) begin
        out_item <= head_item[grant_idx];
    end
end

endmodule

// File: rtl/lane_fabric_top.sv
// Lane fabric top level
// Push router, generated FIFO lanes and pop arbiter

`timescale 1ns/1ns
`include "lane_fabric_defs.svh"

module lane_fabric_top
    import lane_fabric_pkg::*;
(
     input  logic                       clk_push
    ,input  logic                       clk_pop
    ,input  logic                       arst_n

    ,input  logic                       in_req
    ,input  fabric_item_t               in_item
    ,output logic                       in_ack

    ,output logic                       out_req
    ,output fabric_item_t               out_item
    ,input  logic                       out_ack

    ,output logic [`LANE_COUNT-1:0]     lane_full
);

// Push domain wires
logic [`LANE_COUNT-1:0]     push;
fabric_item_t               push_item;

// Pop domain wires
logic [`LANE_COUNT-1:0]     head_valid;
fabric_item_t               head_item [`LANE_COUNT];
logic [`LANE_COUNT-1:0]     pop;

push_router u_push_router (
     .clk_push      (clk_push)
    ,.arst_n        (arst_n)
    ,.in_req        (in_req)
    ,.in_item       (in_item)
    ,.in_ack        (in_ack)
    ,.lane_full     (lane_full)
    ,.push          (push)
    ,.push_item     (push_item)
);

// All lanes share the push word, the one-hot push picks the writer
for (genvar g = 0; g < `LANE_COUNT; g++) begin : g_lane
    fifo_dc_wdb u_lane (
         .clk_push      (clk_push)
        ,.clk_pop       (clk_pop)
        ,.arst_n        (arst_n)
        ,.push          (push[g])
        ,.push_item     (push_item)
        ,.full          (lane_full[g])
        ,.pop           (pop[g])
        ,.head_valid    (head_valid[g])
        ,.head_item     (head_item[g])
    );
end

pop_arbiter u_pop_arbiter (
     .clk_pop       (clk_pop)
    ,.arst_n        (arst_n)
    ,.head_valid    (head_valid)
    ,.head_item     (head_item)
    ,.pop           (pop)
    ,.out_req       (out_req)
    ,.out_item      (out_item)
    ,.out_ack       (out_ack)
);

endmodule

// File: verif/clk_gen.sv
// Test clocks for the push and pop domains
// Power-on reset held for 8 push cycles

`timescale 1ns/1ns

module clk_gen (
     output logic   clk_push
    ,output logic   clk_pop
    ,output logic   arst_n
);

// Push clock, 20 ns period
initial begin
    clk_push = 1'b0;
    forever #10 clk_push = ~clk_push;
end

// Pop clock, 30 ns period, unrelated in phase to the push clock
initial begin
    clk_pop = 1'b0;
    forever #15 clk_pop = ~clk_pop;
end

// Release lands on a falling push edge, away from every rising edge
initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk_push);
    @(negedge clk_push);
    arst_n = 1'b1;
end

endmodule

// File: verif/lane_fabric_props.sv
// Handshake assertions for the lane fabric
// One checker, bound into the push router and into the pop arbiter

`timescale 1ns/1ns

module lane_fabric_props
    import lane_fabric_pkg::*;
(
     input  logic           clk
    ,input  logic           rst_n
    ,input  logic           req
    ,input  logic           ack
    ,input  fabric_item_t   item
    ,input  logic           item_hold
    ,input  logic           strobe_ok
);

// The item may only change once its hold window has closed
a_item_stable: assert property (@(posedge clk) disable iff (!rst_n)
    item_hold |=> (!item_hold || $stable(item)))
    else $error("handshake item changed inside its hold window");

// An acknowledge answers a request and never comes on its own
// A registered ack may show up one edge after the source already dropped req
a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> (req || $past(req)))
    else $error("acknowledge rose while no request was pending");

// Push never meets a full lane and pop never meets an empty head
a_strobe_ok: assert property (@(posedge clk) disable iff (!rst_n)
    strobe_ok)
    else $error("lane strobe issued to a lane that could not take it");

endmodule

//--------------------------------------------------
// Attachment to the two handshake owners
//--------------------------------------------------

bind push_router lane_fabric_props u_push_props (
     .clk           (clk_push)
    ,.rst_n         (rst_n)
    ,.req           (in_req)
    ,.ack           (in_ack)
    ,.item          (in_item)
    ,.item_hold     (in_req && !in_ack)
    ,.strobe_ok     ((push & lane_full) == '0)
);

bind pop_arbiter lane_fabric_props u_pop_props (
     .clk           (clk_pop)
    ,.rst_n         (rst_n)
    ,.req           (out_req)
    ,.ack           (out_ack)
    ,.item          (out_item)
    ,.item_hold     (out_req)
    ,.strobe_ok     ((pop & ~head_valid) == '0)
);

// File: verif/tb_lane_fabric.sv
// Trace-driven testbench for the lane fabric
// Push driver, output sink with scoreboard, watchdog and the final report

`timescale 1ns/1ns
`include "lane_fabric_defs.svh"

module tb_lane_fabric
    import lane_fabric_pkg::*;
();

logic                       clk_push;
logic                       clk_pop;
logic                       arst_n;
logic                       in_req;
fabric_item_t               in_item;
logic                       in_ack;
logic                       out_req;
fabric_item_t               out_item;
logic                       out_ack;
logic [`LANE_COUNT-1:0]     lane_full;

// Trace commands with their arguments and the test each one belongs to
byte                        cmd_q [$];
fabric_item_t               arg_q [$];
string                      name_q [$];
string                      test_of [$];

// Items waiting for the push driver
fabric_item_t               push_q [$];
// Items pushed and not yet seen at the output
fabric_item_t               pend_q [$];
// Outputs listed by E lines, in the order they must appear
fabric_item_t               exp_q [$];

string                      cur_test;
logic                       hold;
int                         held_cnt [`LANE_COUNT];
int                         errors;
int                         errors_at_start;
int                         delivered;
int                         delivered_at_start;
int                         tests;
int                         failed_tests;

clk_gen u_clk_gen (
     .clk_push      (clk_push)
    ,.clk_pop       (clk_pop)
    ,.arst_n        (arst_n)
);

lane_fabric_top u_lane_fabric_top (
     .clk_push      (clk_push)
    ,.clk_pop       (clk_pop)
    ,.arst_n        (arst_n)
    ,.in_req        (in_req)
    ,.in_item       (in_item)
    ,.in_ack        (in_ack)
    ,.out_req       (out_req)
    ,.out_item      (out_item)
    ,.out_ack       (out_ack)
    ,.lane_full     (lane_full)
);

//--------------------------------------------------
// Trace reading and test bookkeeping
//--------------------------------------------------

task automatic read_trace();
    int                         fd;
    int                         code;
    logic [7:0]                 lane;
    logic [`DATA_WIDTH-1:0]     data;
    string                      tok;
    string                      rest;
    string                      name;
    fabric_item_t               item;
    fd = $fopen("verif/lane_trace.txt", "r");
    if (fd == 0) begin
        $display("The trace file verif/lane_trace.txt could not be opened");
        errors++;
        return;
    end
    // Commands are read token by token, so several may share a line
    while ($fscanf(fd, "%s", tok) == 1) begin
        item = '0;
        name = "";
        if (tok[0] == "#") begin
            code = $fgets(rest, fd);
        end else begin
            if (tok == "P" || tok == "E") begin
                code = $fscanf(fd, "%h %h", lane, data);
                if (code != 2) begin
                    $display("The trace has a %s command without a lane and a data word", tok);
                    errors++;
                end
                item.lane = lane_id_t'(lane);
                item.data = data;
            end else if (tok == "W") begin
                code = $fscanf(fd, "%s", name);
            end
            cmd_q.push_back(tok[0]);
            arg_q.push_back(item);
            name_q.push_back(name);
        end
    end
    $fclose(fd);
    // Every command belongs to the test that the next W line closes
    name = "end_of_trace";
    for (int i = cmd_q.size() - 1; i >= 0; i--) begin
        if (cmd_q[i] == "W") begin
            name = name_q[i];
        end
        test_of.push_front(name);
    end
endtask

task automatic close_test(input string name);
    tests++;
    if (errors == errors_at_start) begin
        $display("[test] %s ok, %0d items delivered", name, delivered - delivered_at_start);
    end else begin
        failed_tests++;
        $display("[test] %s failed with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start    = errors;
    delivered_at_start = delivered;
endtask

task automatic check_reset();
    wait (arst_n == 1'b1);
    repeat (4) @(negedge clk_push);
    repeat (4) @(negedge clk_pop);
    if (in_ack != 1'b0) begin
        $display("[ERROR] reset_state: in_ack expected 0, actual %b", in_ack);
        errors++;
    end
    if (out_req != 1'b0) begin
        $display("[ERROR] reset_state: out_req expected 0, actual %b", out_req);
        errors++;
    end
    if (lane_full != '0) begin
        $display("[ERROR] reset_state: lane_full expected 0, actual %b", lane_full);
        errors++;
    end
    close_test("reset_state");
endtask

//--------------------------------------------------
// Scoreboard
//--------------------------------------------------

// Per-lane order comes from the oldest pending item of the same lane
task automatic check_output(input fabric_item_t got);
    int idx;
    idx = -1;
    for (int k = 0; k < pend_q.size(); k++) begin
        if (idx < 0 && pend_q[k].lane == got.lane) begin
            idx = k;
        end
    end
    if (idx < 0) begin
        $display("%s: lane %0d delivered data %h that was never pushed",
                 cur_test, got.lane, got.data);
        errors++;
    end else begin
        if (pend_q[idx].data != got.data) begin
            $display("[ERROR] %s: lane %0d expected data %h, actual %h",
                     cur_test, got.lane, pend_q[idx].data, got.data);
            errors++;
        end
        pend_q.delete(idx);
    end
    // E lines fix the exact order across lanes as well
    if (exp_q.size() > 0) begin
        if (exp_q[0] != got) begin
            $display("[ERROR] %s: expected lane %0d data %h, actual lane %0d data %h",
                     cur_test, exp_q[0].lane, exp_q[0].data, got.lane, got.data);
            errors++;
        end
        void'(exp_q.pop_front());
    end
    delivered++;
endtask

//--------------------------------------------------
// Trace command handlers
//--------------------------------------------------

task automatic release_output();
    int quiet;
    int most;
    int left;
    int taken [`LANE_COUNT];
    quiet = 0;
    most  = 0;
    // A request left unanswered for 40 cycles means the router is stalled
    while (push_q.size() > 0 && quiet < 40) begin
        @(negedge clk_push);
        if (in_req && !in_ack) begin
            quiet++;
        end else begin
            quiet = 0;
        end
    end
    // Items each lane took under hold, without those still waiting for the driver
    for (int k = 0; k < `LANE_COUNT; k++) begin
        left = 0;
        for (int j = 0; j < push_q.size(); j++) begin
            if (push_q[j].lane == k) begin
                left++;
            end
        end
        taken[k] = held_cnt[k] - left;
        if (taken[k] > most) begin
            most = taken[k];
        end
    end
    // Under hold a lane holds its RAM, the double buffer and the arbiter's latched item
    if (push_q.size() > 0) begin
        if (!lane_full[push_q[0].lane]) begin
            $display("[ERROR] %s: lane_full[%0d] expected 1, actual 0",
                     cur_test, push_q[0].lane);
            errors++;
        end
        if (taken[push_q[0].lane] <= `FIFO_DEPTH + 2) begin
            $display("%s: push to lane %0d stalled after %0d items with room left in the lane",
                     cur_test, push_q[0].lane, taken[push_q[0].lane]);
            errors++;
        end
    end
    if (most > `FIFO_DEPTH + 3) begin
        $display("%s: a lane accepted %0d items while the output was held", cur_test, most);
        errors++;
    end
    // Let the last pushes reach the lane heads before the sink answers
    repeat (20) @(negedge clk_pop);
    hold = 1'b0;
endtask

task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while (waited < 2000 && (push_q.size() > 0 || pend_q.size() > 0 || out_req || out_ack)) begin
        @(negedge clk_push);
        waited++;
    end
    if (push_q.size() > 0 || pend_q.size() > 0) begin
        $display("%s: %0d items were never delivered", name, pend_q.size());
        errors++;
    end
    if (exp_q.size() > 0) begin
        $display("%s: %0d listed outputs never appeared", name, exp_q.size());
        errors++;
        exp_q.delete();
    end
    close_test(name);
endtask

//--------------------------------------------------
// Push driver and output sink
//--------------------------------------------------

// Four-phase source, one item at a time, inputs change on falling edges
initial begin
    in_req  = 1'b0;
    in_item = '0;
    forever begin
        @(negedge clk_push);
        if (push_q.size() > 0 && !in_ack) begin
            in_item = push_q[0];
            in_req  = 1'b1;
            @(negedge clk_push);
            while (!in_ack) @(negedge clk_push);
            in_req = 1'b0;
            @(negedge clk_push);
            while (in_ack) @(negedge clk_push);
            void'(push_q.pop_front());
        end
    end
end

// Four-phase sink with a random answer delay, silent while held
initial begin
    out_ack = 1'b0;
    void'($urandom(32'h8bc3c926));
    forever begin
        @(negedge clk_pop);
        if (out_req && !hold) begin
            repeat ($urandom_range(3, 0)) @(negedge clk_pop);
            check_output(out_item);
            out_ack = 1'b1;
            while (out_req) @(negedge clk_pop);
            out_ack = 1'b0;
        end
    end
end

//--------------------------------------------------
// Main sequence
//--------------------------------------------------

initial begin
    int limit;
    hold               = 1'b0;
    held_cnt           = '{default: 0};
    errors             = 0;
    errors_at_start    = 0;
    delivered          = 0;
    delivered_at_start = 0;
    tests              = 0;
    failed_tests       = 0;
    cur_test           = "reset_state";
    read_trace();
    limit = (cmd_q.size() + 1) * 200;
    fork
        begin
            repeat (limit) @(posedge clk_push);
            $display("Watchdog expired after %0d clk_push cycles, the fabric stopped", limit);
            $display("TEST FAIL");
            $finish;
        end
    join_none
    check_reset();
    for (int i = 0; i < cmd_q.size(); i++) begin
        cur_test = test_of[i];
        case (cmd_q[i])
            "P": begin
                push_q.push_back(arg_q[i]);
                pend_q.push_back(arg_q[i]);
                if (hold) begin
                    held_cnt[arg_q[i].lane]++;
                end
            end
            "E": exp_q.push_back(arg_q[i]);
            "H": begin
                hold     = 1'b1;
                held_cnt = '{default: 0};
            end
            "R": release_output();
            "W": finish_test(name_q[i]);
            default: begin
                $display("%s: the trace holds an unknown command %c", cur_test, cmd_q[i]);
                errors++;
            end
        endcase
    end
    if (push_q.size() > 0 || pend_q.size() > 0) begin
        $display("The trace ended with %0d items unpushed and %0d undelivered",
                 push_q.size(), pend_q.size());
        errors++;
    end
    $display("Summary %0d tests, %0d failed, %0d items delivered, %0d errors",
             tests, failed_tests, delivered, errors);
    if (errors == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

endmodule

// File: all.f
+incdir+rtl
rtl/lane_fabric_pkg.sv
rtl/fifo_ctl_dc.sv
rtl/double_buffer.sv
rtl/fifo_dc_wdb.sv
rtl/push_router.sv
rtl/pop_arbiter.sv
rtl/lane_fabric_top.sv
verif/clk_gen.sv
verif/lane_fabric_props.sv
verif/tb_lane_fabric.sv

// File: Makefile
TOP := tb_lane_fabric

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

# Build, run, and pass only when the pass line shows up in the output
sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: verif/lane_trace.txt
# Columns are command, lane and data in hex, read as tokens so lines may hold several
# P pushes an item, E gives the next output, H and R hold and release out_ack, W name ends a test
# Four items through lane 1 keep their order
P 1 1a01  P 1 1a02  P 1 1a03  P 1 1a04
W lane_order
# Mixed lanes under random out_ack delays
P 0 2b00  P 3 2b30  P 2 2b20  P 0 2b01
P 1 2b10  P 3 2b31  P 2 2b21  P 1 2b11
W mixed_lanes
# Twelve items into lane 2 with out_ack held, the last one must stall
H
P 2 3c00  P 2 3c01  P 2 3c02  P 2 3c03
P 2 3c04  P 2 3c05  P 2 3c06  P 2 3c07
P 2 3c08  P 2 3c09  P 2 3c0a  P 2 3c0b
R
W back_pressure
# Three items per lane with out_ack held, then drained in rotation
H
P 0 4d00  P 0 4d01  P 0 4d02
P 1 4d10  P 1 4d11  P 1 4d12
P 2 4d20  P 2 4d21  P 2 4d22
P 3 4d30  P 3 4d31  P 3 4d32
E 0 4d00  E 1 4d10  E 2 4d20  E 3 4d30
E 0 4d01  E 1 4d11  E 2 4d21  E 3 4d31
E 0 4d02  E 1 4d12  E 2 4d22  E 3 4d32
R
W round_robin
# Free-running traffic again after the held phases
P 3 5e30  P 2 5e20  P 1 5e10  P 0 5e00
P 3 5e31  P 0 5e01  P 2 5e21  P 1 5e11
W after_release
